// ==== vlog.f ====
hdl/cardPkg.sv
hdl/handPkg.sv
hdl/handFeaturesIf.sv
hdl/rankMatcher.sv
hdl/straightDetector.sv
hdl/featureStage.sv
hdl/handClassifier.sv
hdl/pokerHand.sv
dv/pokerHand_sva.sv
dv/pokerHandTb.sv

// ==== Makefile ====
# Verilator build and run for the poker hand classifier

TOP := pokerHandTb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the obj_dir build folder"

test:
	verilator --binary --assert -Wno-fatal -f vlog.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

// ==== dv/pokerHandTb.sv ====
`timescale 1ns/1ps

module pokerHandTb;

	logic clk;
	logic rstN;
	logic cardValid;
	logic [cardPkg::cardW-1:0] card0;
	logic [cardPkg::cardW-1:0] card1;
	logic [cardPkg::cardW-1:0] card2;
	logic [cardPkg::cardW-1:0] card3;
	logic [cardPkg::cardW-1:0] card4;
	logic handValid;
	logic [handPkg::typeW-1:0] handType;

	// hand table with card0 in the low bits
	logic [cardPkg::handSize*cardPkg::cardW-1:0] tblHand [$];
	logic [handPkg::typeW-1:0] tblType [$];
	string tblLabel [$];

	// hands in flight
	logic [handPkg::typeW-1:0] expQ [$];
	int issueQ [$];
	string labelQ [$];

	logic [handPkg::typeW-1:0] pendingExp;
	string pendingLabel;
	logic [handPkg::typeW-1:0] expHead;
	int issueHead;
	string labelHead;

	logic [15:0] lfsrState;
	logic [cardPkg::handSize*cardPkg::cardW-1:0] randHand;

	int negCount = 0;
	int checkedCount = 0;
	int errorCount = 0;
	int timeoutCount = 0;

	pokerHand uut (
		.clk      (clk),
		.rstN     (rstN),
		.cardValid(cardValid),
		.card0    (card0),
		.card1    (card1),
		.card2    (card2),
		.card3    (card3),
		.card4    (card4),
		.handValid(handValid),
		.handType (handType)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [cardPkg::cardW-1:0] cardOf(input logic [1:0] suit,
			input logic [3:0] rank);
		return {suit, rank};
	endfunction

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic stepLfsr();
		logic fb;
		fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
		lfsrState = {lfsrState[14:0], fb};
		return fb;
	endfunction

	function automatic logic [cardPkg::cardW-1:0] randomCard();
		logic [cardPkg::cardW-1:0] c;
		c = '0;
		for (int b = 0; b < cardPkg::cardW; b++) begin
			c = {c[cardPkg::cardW-2:0], stepLfsr()};
		end
		return c;
	endfunction

	// reference model straight from the hand rules
	function automatic logic [handPkg::typeW-1:0] expectedType(
			input logic [cardPkg::handSize*cardPkg::cardW-1:0] hand);
		logic [3:0] r [5];
		logic [1:0] s [5];
		logic [15:0] seen;
		int pairs;
		logic sameSuit;
		logic run;
		for (int i = 0; i < 5; i++) begin
			r[i] = hand[i*6 +: 4];
			s[i] = hand[i*6+4 +: 2];
		end
		pairs = 0;
		for (int i = 0; i < 4; i++) begin
			for (int j = i + 1; j < 5; j++) begin
				if (r[i] == r[j]) begin
					pairs++;
				end
			end
		end
		sameSuit = 1'b1;
		seen = '0;
		for (int i = 0; i < 5; i++) begin
			if (s[i] != s[0]) begin
				sameSuit = 1'b0;
			end
			if (r[i] >= 1 && r[i] <= 13) begin
				seen[r[i]] = 1'b1;
			end
		end
		run = 1'b0;
		for (int lo = 1; lo <= 9; lo++) begin
			if (seen[lo +: 5] == 5'h1f) begin
				run = 1'b1;
			end
		end
		// ten to ace
		if (seen[13:10] == 4'hf && seen[1]) begin
			run = 1'b1;
		end
		if (sameSuit && run) return handPkg::straightFlush;
		if (pairs >= 6) return handPkg::fourOfAKind;
		if (pairs == 4) return handPkg::fullHouse;
		if (sameSuit) return handPkg::flush;
		if (run) return handPkg::straight;
		if (pairs == 3) return handPkg::threeOfAKind;
		if (pairs == 2) return handPkg::twoPairs;
		if (pairs == 1) return handPkg::onePair;
		return handPkg::highCard;
	endfunction

	task automatic addEntry(input logic [5:0] c0, input logic [5:0] c1, input logic [5:0] c2,
			input logic [5:0] c3, input logic [5:0] c4,
			input logic [handPkg::typeW-1:0] kind, input string label);
		tblHand.push_back({c4, c3, c2, c1, c0});
		tblType.push_back(kind);
		tblLabel.push_back(label);
	endtask

	task automatic buildTable();
		addEntry(cardOf(0, 1), cardOf(1, 3), cardOf(2, 5), cardOf(3, 7), cardOf(0, 9),
			handPkg::highCard, "high card");
		addEntry(cardOf(0, 2), cardOf(1, 2), cardOf(2, 5), cardOf(3, 9), cardOf(0, 13),
			handPkg::onePair, "one pair");
		addEntry(cardOf(0, 4), cardOf(1, 4), cardOf(2, 8), cardOf(3, 8), cardOf(0, 12),
			handPkg::twoPairs, "two pairs");
		addEntry(cardOf(0, 7), cardOf(1, 7), cardOf(2, 7), cardOf(3, 2), cardOf(0, 11),
			handPkg::threeOfAKind, "three of a kind");
		addEntry(cardOf(0, 5), cardOf(1, 6), cardOf(2, 7), cardOf(3, 8), cardOf(0, 9),
			handPkg::straight, "straight 5-9");
		addEntry(cardOf(3, 3), cardOf(1, 1), cardOf(2, 5), cardOf(0, 2), cardOf(1, 4),
			handPkg::straight, "ace-low straight");
		addEntry(cardOf(0, 10), cardOf(1, 11), cardOf(2, 12), cardOf(3, 13), cardOf(0, 1),
			handPkg::straight, "ten-to-ace straight");
		addEntry(cardOf(2, 1), cardOf(2, 13), cardOf(2, 12), cardOf(2, 11), cardOf(2, 10),
			handPkg::straightFlush, "ten-to-ace straight flush");
		addEntry(cardOf(1, 2), cardOf(1, 3), cardOf(1, 4), cardOf(1, 5), cardOf(1, 6),
			handPkg::straightFlush, "straight flush 2-6");
		addEntry(cardOf(0, 13), cardOf(1, 1), cardOf(2, 2), cardOf(3, 3), cardOf(0, 4),
			handPkg::highCard, "king-ace-2-3-4");
		addEntry(cardOf(3, 13), cardOf(3, 1), cardOf(3, 2), cardOf(3, 3), cardOf(3, 4),
			handPkg::flush, "king-ace-2-3-4 suited");
		addEntry(cardOf(3, 2), cardOf(3, 5), cardOf(3, 9), cardOf(3, 11), cardOf(3, 13),
			handPkg::flush, "flush");
		addEntry(cardOf(0, 3), cardOf(1, 3), cardOf(2, 3), cardOf(3, 9), cardOf(0, 9),
			handPkg::fullHouse, "full house");
		addEntry(cardOf(1, 3), cardOf(1, 3), cardOf(1, 3), cardOf(1, 9), cardOf(1, 9),
			handPkg::fullHouse, "full house suited");
		addEntry(cardOf(0, 8), cardOf(1, 8), cardOf(2, 8), cardOf(3, 8), cardOf(0, 2),
			handPkg::fourOfAKind, "four of a kind");
		addEntry(cardOf(0, 6), cardOf(1, 6), cardOf(2, 6), cardOf(3, 6), cardOf(0, 6),
			handPkg::fourOfAKind, "five of a kind");
		addEntry(cardOf(2, 6), cardOf(2, 6), cardOf(2, 6), cardOf(2, 6), cardOf(2, 6),
			handPkg::fourOfAKind, "five of a kind suited");
		addEntry(cardOf(0, 10), cardOf(1, 11), cardOf(2, 12), cardOf(3, 13), cardOf(0, 14),
			handPkg::highCard, "rank 14 breaks straight");
		addEntry(cardOf(0, 0), cardOf(1, 1), cardOf(2, 2), cardOf(3, 3), cardOf(0, 4),
			handPkg::highCard, "rank 0 breaks straight");
		addEntry(cardOf(0, 14), cardOf(1, 14), cardOf(2, 2), cardOf(3, 5), cardOf(0, 9),
			handPkg::onePair, "pair of 14");
		addEntry(cardOf(0, 15), cardOf(1, 15), cardOf(2, 15), cardOf(3, 0), cardOf(0, 0),
			handPkg::fullHouse, "15s over 0s");
		addEntry(cardOf(0, 0), cardOf(1, 0), cardOf(2, 3), cardOf(3, 3), cardOf(0, 7),
			handPkg::twoPairs, "0s and 3s");
		addEntry(cardOf(0, 9), cardOf(1, 10), cardOf(2, 11), cardOf(3, 12), cardOf(0, 13),
			handPkg::straight, "straight 9-king");
		addEntry(cardOf(1, 0), cardOf(1, 14), cardOf(1, 15), cardOf(1, 3), cardOf(1, 5),
			handPkg::flush, "flush with odd ranks");
	endtask

	// called on a falling edge
	task automatic driveHand(input logic [cardPkg::handSize*cardPkg::cardW-1:0] hand,
			input logic [handPkg::typeW-1:0] kind, input string label);
		card0 = hand[0 +: cardPkg::cardW];
		card1 = hand[cardPkg::cardW +: cardPkg::cardW];
		card2 = hand[2*cardPkg::cardW +: cardPkg::cardW];
		card3 = hand[3*cardPkg::cardW +: cardPkg::cardW];
		card4 = hand[4*cardPkg::cardW +: cardPkg::cardW];
		cardValid = 1'b1;
		pendingExp = kind;
		pendingLabel = label;
	endtask

	task automatic waitForDrain();
		for (int i = 0; i < 20 && expQ.size() > 0; i++) begin
			@(posedge clk);
		end
		if (expQ.size() != 0) begin
			$display("timeout: %0d results never came out", expQ.size());
			timeoutCount++;
		end
	endtask

	// accepted hands with the falling edge they were driven on
	always @(posedge clk) begin
		if (rstN && cardValid) begin
			expQ.push_back(pendingExp);
			issueQ.push_back(negCount);
			labelQ.push_back(pendingLabel);
		end
	end

	// outputs settle after the rising edge
	always @(negedge clk) begin
		negCount++;
		if (handValid === 1'b1) begin
			if (expQ.size() == 0) begin
				$display("handValid went high with no hand in flight at %0t", $time);
				errorCount++;
			end else begin
				expHead = expQ.pop_front();
				issueHead = issueQ.pop_front();
				labelHead = labelQ.pop_front();
				checkedCount++;
				if (negCount - issueHead != 2) begin
					$display("hand '%s' came out after %0d cycles instead of 2",
						labelHead, negCount - issueHead);
					errorCount++;
				end
				if (handType !== expHead) begin
					$display("[FAIL] handType (%s): expected %h, got %h",
						labelHead, expHead, handType);
					errorCount++;
				end
			end
		end else if (handValid !== 1'b0) begin
			$display("handValid is unknown at %0t", $time);
			errorCount++;
		end else if (issueQ.size() > 0 && negCount - issueQ[0] >= 2) begin
			$display("no result for hand '%s' two cycles after it was offered", labelQ[0]);
			errorCount++;
			void'(expQ.pop_front());
			void'(issueQ.pop_front());
			void'(labelQ.pop_front());
		end
	end

	initial begin
		rstN = 1'b0;
		cardValid = 1'b0;
		card0 = '0;
		card1 = '0;
		card2 = '0;
		card3 = '0;
		card4 = '0;
		pendingExp = handPkg::highCard;
		pendingLabel = "";
		lfsrState = 16'd45922;
		buildTable();

		repeat (2) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;

		// idle while handType holds its reset code
		for (int i = 0; i < 4; i++) begin
			@(negedge clk);
			if (handType !== handPkg::highCard) begin
				$display("[FAIL] handType after reset: expected %h, got %h",
					handPkg::highCard, handType);
				errorCount++;
			end
		end

		// table hands back to back
		for (int i = 0; i < tblHand.size(); i++) begin
			driveHand(tblHand[i], tblType[i], tblLabel[i]);
			@(negedge clk);
		end
		cardValid = 1'b0;
		repeat (3) @(negedge clk);

		for (int n = 0; n < 500; n++) begin
			for (int k = 0; k < cardPkg::handSize; k++) begin
				randHand[k*cardPkg::cardW +: cardPkg::cardW] = randomCard();
			end
			driveHand(randHand, expectedType(randHand), $sformatf("random %0d", n));
			@(negedge clk);
		end
		cardValid = 1'b0;

		waitForDrain();
		repeat (4) @(negedge clk);

		$display("hands checked %0d, errors %0d, timeouts %0d",
			checkedCount, errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== dv/pokerHand_sva.sv ====
`timescale 1ns/1ps

module pokerHandSva (
	input logic                      clk,
	input logic                      rstN,
	input logic                      cardValid,
	input logic                      handValid,
	input logic [handPkg::typeW-1:0] handType
);

	// first cycle out of reset
	property validLowAfterReset;
		@(posedge clk) !rstN |=> !handValid;
	endproperty

	// two register stages, no stall
	property validFollowsStrobe;
		@(posedge clk) (rstN && $past(rstN) && $past(rstN, 2)) |->
			(handValid == $past(cardValid, 2));
	endproperty

	property typeInRange;
		@(posedge clk) disable iff (!rstN) handValid |-> (handType <= handPkg::straightFlush);
	endproperty

	assertValidLow: assert property (validLowAfterReset)
		else $error("handValid high right after reset");
	assertLatency: assert property (validFollowsStrobe)
		else $error("handValid does not follow cardValid by two cycles");
	assertTypeRange: assert property (typeInRange)
		else $error("handType out of range: %h", handType);

endmodule

bind pokerHand pokerHandSva uSva (
	.clk      (clk),
	.rstN     (rstN),
	.cardValid(cardValid),
	.handValid(handValid),
	.handType (handType)
);

// ==== hdl/pokerHand.sv ====
`timescale 1ns/1ps

module pokerHand (
	input  logic                      clk,
	input  logic                      rstN,
	input  logic                      cardValid,
	input  logic [cardPkg::cardW-1:0] card0,
	input  logic [cardPkg::cardW-1:0] card1,
	input  logic [cardPkg::cardW-1:0] card2,
	input  logic [cardPkg::cardW-1:0] card3,
	input  logic [cardPkg::cardW-1:0] card4,
	output logic                      handValid,
	output logic [handPkg::typeW-1:0] handType
);

	logic [cardPkg::handSize-1:0][cardPkg::cardW-1:0] cards;

	// card0 lands in slot 0
	assign cards = {card4, card3, card2, card1, card0};

	handFeaturesIf feat ();

	// stage 1, pair count and the two flags
	featureStage uFeatures (
		.clk      (clk),
		.rstN     (rstN),
		.cardValid(cardValid),
		.cards    (cards),
		.feat     (feat.producer)
	);

	// stage 2, category code
	handClassifier uClassifier (
		.clk      (clk),
		.rstN     (rstN),
		.feat     (feat.consumer),
		.handValid(handValid),
		.handType (handType)
	);

endmodule

// ==== hdl/handClassifier.sv ====
`timescale 1ns/1ps

module handClassifier (
	input  logic                     clk,
	input  logic                     rstN,
	handFeaturesIf.consumer          feat,
	output logic                     handValid,
	output logic [handPkg::typeW-1:0] handType
);

	logic [handPkg::typeW-1:0] nextType;

	// highest category wins
	// full house beats flush, straight needs no pair check
	always_comb begin
		if (feat.isFlush && feat.isStraight) begin
			nextType = handPkg::straightFlush;
		end else if (feat.pairCount >= handPkg::pairsFour) begin
			// five alike lands here too
			nextType = handPkg::fourOfAKind;
		end else if (feat.pairCount == handPkg::pairsFull) begin
			nextType = handPkg::fullHouse;
		end else if (feat.isFlush) begin
			nextType = handPkg::flush;
		end else if (feat.isStraight) begin
			nextType = handPkg::straight;
		end else if (feat.pairCount == handPkg::pairsThree) begin
			nextType = handPkg::threeOfAKind;
		end else if (feat.pairCount == handPkg::pairsTwo) begin
			nextType = handPkg::twoPairs;
		end else if (feat.pairCount == handPkg::pairsOne) begin
			nextType = handPkg::onePair;
		end else begin
			nextType = handPkg::highCard;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			handValid <= 1'b0;
			handType <= handPkg::highCard;
		end else begin
			handValid <= feat.featValid;
			if (feat.featValid) begin
				handType <= nextType;
			end
		end
	end

endmodule

// ==== hdl/featureStage.sv ====
`timescale 1ns/1ps

module featureStage (
	input  logic                                             clk,
	input  logic                                             rstN,
	input  logic                                             cardValid,
	input  logic [cardPkg::handSize-1:0][cardPkg::cardW-1:0] cards,
	handFeaturesIf.producer                                  feat
);

	logic [cardPkg::pairCountW-1:0] pairCount;
	logic [cardPkg::suitW-1:0] leadSuit;
	logic isStraight;
	logic isFlush;

	rankMatcher uMatcher (
		.cards    (cards),
		.pairCount(pairCount)
	);

	straightDetector uStraight (
		.cards     (cards),
		.isStraight(isStraight)
	);

	// suit is the top field of the card word
	assign leadSuit = cards[0][cardPkg::cardW-1 -: cardPkg::suitW];

	// flush when every suit equals the first one
	always_comb begin
		isFlush = 1'b1;
		for (int i = 1; i < cardPkg::handSize; i++) begin
			if (cards[i][cardPkg::cardW-1 -: cardPkg::suitW] != leadSuit) begin
				isFlush = 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			feat.featValid <= 1'b0;
		end else begin
			feat.featValid <= cardValid;
		end
	end

	// features follow the strobe, one hand per clock
	always_ff @(posedge clk) begin
		if (cardValid) begin
			feat.pairCount <= pairCount;
			feat.isFlush <= isFlush;
			feat.isStraight <= isStraight;
		end
	end

endmodule

// ==== hdl/straightDetector.sv ====
`timescale 1ns/1ps

module straightDetector (
	input  logic [cardPkg::handSize-1:0][cardPkg::cardW-1:0] cards,
	output logic                                             isStraight
);

	localparam int unsigned lastStart = cardPkg::rankHigh - cardPkg::runLen + 1;
	localparam int unsigned tenRank = cardPkg::rankHigh - cardPkg::runLen + 2;

	logic [cardPkg::rankHigh:cardPkg::rankLow] present;
	logic [cardPkg::rankW-1:0] rank;
	logic lowRun;
	logic aceHigh;

	// one presence bit per legal rank
	// ranks 0, 14 and 15 are simply dropped here
	always_comb begin
		present = '0;
		rank = '0;
		for (int i = 0; i < cardPkg::handSize; i++) begin
			rank = cards[i][cardPkg::rankW-1:0];
			if (rank >= cardPkg::rankLow && rank <= cardPkg::rankHigh) begin
				present[rank] = 1'b1;
			end
		end
	end

	// ace-low A2345 up to 9TJQK
	always_comb begin
		lowRun = 1'b0;
		for (int s = cardPkg::rankLow; s <= lastStart; s++) begin
			if (&present[s +: cardPkg::runLen]) begin
				lowRun = 1'b1;
			end
		end
	end

	// ten to king with the ace wrapping round
	assign aceHigh = (&present[tenRank +: cardPkg::runLen - 1]) && present[cardPkg::rankLow];

	// five distinct ranks already rule out any pair
	assign isStraight = lowRun || aceHigh;

endmodule

// ==== hdl/rankMatcher.sv ====
`timescale 1ns/1ps

module rankMatcher (
	input  logic [cardPkg::handSize-1:0][cardPkg::cardW-1:0] cards,
	output logic [cardPkg::pairCountW-1:0]                   pairCount
);

	logic [cardPkg::rankW-1:0] ranks [cardPkg::handSize];
	logic [cardPkg::pairCountW-1:0] matchSum;

	// rank sits in the low bits of each card
	always_comb begin
		for (int i = 0; i < cardPkg::handSize; i++) begin
			ranks[i] = cards[i][cardPkg::rankW-1:0];
		end
	end

	// every unordered pairing once, ten compares for five cards
	// out-of-range ranks still match each other
	always_comb begin
		matchSum = '0;
		for (int i = 0; i < cardPkg::handSize - 1; i++) begin
			for (int j = i + 1; j < cardPkg::handSize; j++) begin
				if (ranks[i] == ranks[j]) begin
					matchSum = matchSum + 1'b1;
				end
			end
		end
	end

	// sum alone identifies the rank pattern
	assign pairCount = matchSum;

endmodule

// ==== hdl/handFeaturesIf.sv ====
`timescale 1ns/1ps

interface handFeaturesIf;

	logic featValid;
	logic [cardPkg::pairCountW-1:0] pairCount;
	logic isFlush;
	logic isStraight;

	// fields only mean something while featValid is high
	modport producer (
		output featValid,
		output pairCount,
		output isFlush,
		output isStraight
	);

	modport consumer (
		input featValid,
		input pairCount,
		input isFlush,
		input isStraight
	);

endinterface

// ==== hdl/handPkg.sv ====
package handPkg;

	localparam int unsigned typeW = 4;

	// category codes, same order as the gate-level evaluator
	localparam logic [typeW-1:0] highCard = 4'd0;
	localparam logic [typeW-1:0] onePair = 4'd1;
	localparam logic [typeW-1:0] twoPairs = 4'd2;
	localparam logic [typeW-1:0] threeOfAKind = 4'd3;
	localparam logic [typeW-1:0] straight = 4'd4;
	localparam logic [typeW-1:0] flush = 4'd5;
	localparam logic [typeW-1:0] fullHouse = 4'd6;
	localparam logic [typeW-1:0] fourOfAKind = 4'd7;
	localparam logic [typeW-1:0] straightFlush = 4'd8;

	// pair counts over the ten pairings
	// a triple gives 3, triple plus pair gives 4, four alike gives 6
	localparam logic [cardPkg::pairCountW-1:0] pairsOne = 4'd1;
	localparam logic [cardPkg::pairCountW-1:0] pairsTwo = 4'd2;
	localparam logic [cardPkg::pairCountW-1:0] pairsThree = 4'd3;
	localparam logic [cardPkg::pairCountW-1:0] pairsFull = 4'd4;
	localparam logic [cardPkg::pairCountW-1:0] pairsFour = 4'd6;

endpackage

// ==== hdl/cardPkg.sv ====
package cardPkg;

	// card word is {suit, rank}
	localparam int unsigned rankW = 4;
	localparam int unsigned suitW = 2;
	localparam int unsigned cardW = suitW + rankW;

	localparam int unsigned handSize = 5;

	// legal ranks, ace counts as 1
	localparam int unsigned rankLow = 1;
	localparam int unsigned rankHigh = 13;

	// consecutive ranks needed for a straight
	localparam int unsigned runLen = 5;

	// ten pairings at most, so 0 to 10 fits in four bits
	localparam int unsigned pairCountW = 4;

endpackage
